// ==== include/nice_cfg.svh ====
`ifndef NICE_CFG_SVH
`define NICE_CFG_SVH

// data and address widths
`define NICE_XLEN          32
`define NICE_ADDR_SIZE     32

// picture buffer, one jlsd burst fills it
// depth must stay a power of two, 2 to 256
`define NICE_PIC_WORDS     16
`define NICE_PIC_IDX_W     4

// byte step between two burst words
`define NICE_WORD_BYTES    4

// icb size code of a 32 bit access
`define NICE_CMD_SIZE_WORD 2'b10

// custom3 opcode, r type only
`define NICE_OPC_CUSTOM3   7'b1111011

// jlsd, picture load
`define NICE_F3_JLSD       3'b010
`define NICE_F7_JLSD       7'b0000000
// jact, activation
`define NICE_F3_JACT       3'b011
`define NICE_F7_JACT       7'b0000110

`endif

// ==== hw/nice_pkg.sv ====
`default_nettype none

`include "nice_cfg.svh"

package nice_pkg;

   // one word on request, response and memory data
   typedef logic [`NICE_XLEN-1:0] word_t;

   // icb byte address
   typedef logic [`NICE_ADDR_SIZE-1:0] addr_t;

   // picture buffer entry number
   typedef logic [`NICE_PIC_IDX_W-1:0] pic_idx_t;

   // decoded instruction kind
   typedef enum logic [1:0] {
      op_jlsd    = 2'd0,
      op_jact    = 2'd1,
      op_illegal = 2'd2
   } nice_op_e;

   // sequencer states
   // st_load covers the whole memory burst
   typedef enum logic [1:0] {
      st_idle = 2'd0,
      st_load = 2'd1,
      st_resp = 2'd2
   } nice_state_e;

endpackage

`default_nettype wire

// ==== hw/nice_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "nice_cfg.svh"

module nice_decode (
   input  nice_pkg::word_t    req_inst,
   input  logic               req_valid,
   output nice_pkg::nice_op_e op
);
   import nice_pkg::*;

   logic [6:0] opcode;
   logic [2:0] func3;
   logic [6:0] func7;
   logic       is_custom3;
   logic       is_jlsd;
   logic       is_jact;

   ////////////////////
   // field split
   ////////////////////

   // r type layout
   assign opcode = req_inst[6:0];
   assign func3  = req_inst[14:12];
   assign func7  = req_inst[31:25];

   // nothing decodes without a request
   assign is_custom3 = req_valid & (opcode == `NICE_OPC_CUSTOM3);

   ////////////////////
   // function match
   ////////////////////

   // jlsd, burst load from rs1
   assign is_jlsd = is_custom3 &
                    (func3 == `NICE_F3_JLSD) &
                    (func7 == `NICE_F7_JLSD);

   // jact, activation of one buffered word
   assign is_jact = is_custom3 &
                    (func3 == `NICE_F3_JACT) &
                    (func7 == `NICE_F7_JACT);

   // everything else is answered as illegal
   always_comb begin
      if (is_jlsd) begin
         op = op_jlsd;
      end else if (is_jact) begin
         op = op_jact;
      end else begin
         op = op_illegal;
      end
   end

endmodule

`default_nettype wire

// ==== hw/nice_seq.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "nice_cfg.svh"

module nice_seq (
   input  logic                  nice_clk,
   input  logic                  rst,
   input  logic                  req_valid,
   input  nice_pkg::nice_op_e    op,
   input  logic                  icb_cmd_ready,
   input  logic                  icb_rsp_valid,
   input  logic                  icb_rsp_err,
   input  logic                  rsp_ready,
   output logic                  req_ready,
   output nice_pkg::nice_state_e state,
   output logic                  burst_start,
   output logic                  load_done,
   output logic                  err_sticky,
   output logic                  nice_active,
   output logic                  nice_mem_holdup
);
   import nice_pkg::*;

   nice_state_e state_nxt;
   pic_idx_t    rsp_cnt;
   logic        err_r;
   logic        req_hsk;
   logic        rsp_take;
   logic        load_err;

   ////////////////////
   // request side
   ////////////////////

   // jlsd waits for the memory to take its first command
   assign req_ready = (state == st_idle) & req_valid &
                      ((op == op_jlsd) ? icb_cmd_ready : 1'b1);
   assign req_hsk     = req_valid & req_ready;
   assign burst_start = req_hsk & (op == op_jlsd);

   // memory responses only count inside a burst
   assign rsp_take  = (state == st_load) & icb_rsp_valid;
   assign load_done = rsp_take & (rsp_cnt == pic_idx_t'(`NICE_PIC_WORDS - 1));
   assign load_err  = rsp_take & icb_rsp_err;

   // next state
   always_comb begin
      state_nxt = state;
      case (state)
         st_idle: begin
            if (req_hsk) begin
               state_nxt = (op == op_jlsd) ? st_load : st_resp;
            end
         end
         st_load: begin
            if (load_done) begin
               state_nxt = st_resp;
            end
         end
         st_resp: begin
            // rsp_valid is high for the whole of st_resp
            if (rsp_ready) begin
               state_nxt = st_idle;
            end
         end
         default: state_nxt = st_idle;
      endcase
   end

   always_ff @(posedge nice_clk) begin
      if (rst) begin
         state <= st_idle;
      end else begin
         state <= state_nxt;
      end
   end

   // response counter, matches the buffer write order
   always_ff @(posedge nice_clk) begin
      if (rst) begin
         rsp_cnt <= '0;
      end else if (burst_start) begin
         rsp_cnt <= '0;
      end else if (rsp_take) begin
         rsp_cnt <= rsp_cnt + 1'b1;
      end
   end

   ////////////////////
   // error bit
   ////////////////////

   // illegal starts set, a burst starts clear
   always_ff @(posedge nice_clk) begin
      if (rst) begin
         err_r <= 1'b0;
      end else if (req_hsk) begin
         err_r <= (op == op_illegal);
      end else if (load_err) begin
         err_r <= 1'b1;
      end
   end

   // includes the response landing this cycle
   assign err_sticky = (state == st_idle) ? (op == op_illegal) : (err_r | load_err);

   assign nice_active     = (state == st_idle) ? req_valid : 1'b1;
   assign nice_mem_holdup = (state == st_load);

   a_resp_hold: assert property (@(posedge nice_clk) disable iff (rst)
      (state == st_resp) && !rsp_ready |=> state == st_resp);

endmodule

`default_nettype wire

// ==== hw/nice_lsu.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "nice_cfg.svh"

module nice_lsu (
   input  logic            nice_clk,
   input  logic            rst,
   input  logic            burst_start,
   input  nice_pkg::addr_t req_rs1,
   input  logic            icb_cmd_ready,
   output logic            icb_cmd_valid,
   output nice_pkg::addr_t icb_cmd_addr
);
   import nice_pkg::*;

   addr_t    addr_acc;
   pic_idx_t cmd_cnt;
   logic     busy;
   logic     cmd_hsk;
   logic     cmd_last;

   ////////////////////
   // command channel
   ////////////////////

   // first command leaves with the request handshake
   assign icb_cmd_valid = burst_start | busy;
   assign icb_cmd_addr  = burst_start ? req_rs1 : addr_acc;
   assign cmd_hsk       = icb_cmd_valid & icb_cmd_ready;

   // cmd_cnt holds the number already accepted
   assign cmd_last = (cmd_cnt == pic_idx_t'(`NICE_PIC_WORDS - 1));

   // next word address
   always_ff @(posedge nice_clk) begin
      if (cmd_hsk) begin
         addr_acc <= icb_cmd_addr + addr_t'(`NICE_WORD_BYTES);
      end
   end

   // burst control
   always_ff @(posedge nice_clk) begin
      if (rst) begin
         busy    <= 1'b0;
         cmd_cnt <= '0;
      end else if (burst_start) begin
         // req_ready made sure this one was taken
         busy    <= 1'b1;
         cmd_cnt <= pic_idx_t'(1);
      end else if (cmd_hsk) begin
         cmd_cnt <= cmd_cnt + 1'b1;
         if (cmd_last) begin
            busy <= 1'b0;
         end
      end
   end

   a_cmd_hold: assert property (@(posedge nice_clk) disable iff (rst)
      icb_cmd_valid && !icb_cmd_ready |=> icb_cmd_valid && $stable(icb_cmd_addr));

endmodule

`default_nettype wire

// ==== hw/nice_picbuf.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "nice_cfg.svh"

module nice_picbuf (
   input  logic               nice_clk,
   input  logic               rst,
   input  logic               burst_start,
   input  logic               wr_en,
   input  nice_pkg::word_t    wr_data,
   input  nice_pkg::pic_idx_t rd_idx,
   output nice_pkg::word_t    act_data,
   output nice_pkg::word_t    last_data
);
   import nice_pkg::*;

   word_t    pic_mem [`NICE_PIC_WORDS];
   pic_idx_t wr_idx;
   pic_idx_t prev_idx;
   word_t    rd_word;

   ////////////////////
   // write side
   ////////////////////

   // entry i takes response i of the burst
   always_ff @(posedge nice_clk) begin
      if (rst) begin
         wr_idx <= '0;
      end else if (burst_start) begin
         wr_idx <= '0;
      end else if (wr_en) begin
         wr_idx <= wr_idx + 1'b1;
      end
   end

   always_ff @(posedge nice_clk) begin
      if (wr_en) begin
         pic_mem[wr_idx] <= wr_data;
      end
   end

   // newest word, the one landing now wins
   assign prev_idx  = wr_idx - 1'b1;
   assign last_data = wr_en ? wr_data : pic_mem[prev_idx];

   ////////////////////
   // activation port
   ////////////////////

   assign rd_word = pic_mem[rd_idx];

   // negative words clamp to zero
   assign act_data = rd_word[`NICE_XLEN-1] ? '0 : rd_word;

endmodule

`default_nettype wire

// ==== hw/nice_rsp.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "nice_cfg.svh"

module nice_rsp (
   input  logic                  nice_clk,
   input  logic                  rst,
   input  nice_pkg::nice_state_e state,
   input  nice_pkg::nice_op_e    op,
   input  nice_pkg::word_t       act_data,
   input  nice_pkg::word_t       last_data,
   input  logic                  err_sticky,
   input  logic                  rsp_ready,
   output logic                  rsp_valid,
   output nice_pkg::word_t       rsp_rdat,
   output logic                  rsp_err
);
   import nice_pkg::*;

   word_t res_data;
   logic  hold;

   ////////////////////
   // result select
   ////////////////////

   // illegal answers zero data
   always_comb begin
      case (op)
         op_jlsd: res_data = last_data;
         op_jact: res_data = act_data;
         default: res_data = '0;
      endcase
   end

   // response is up for the whole of st_resp
   assign rsp_valid = (state == st_resp);

   // frozen while the core waits on rsp_ready
   assign hold = rsp_valid & ~rsp_ready;

   // last load before freezing is the edge into st_resp
   always_ff @(posedge nice_clk) begin
      if (!hold) begin
         rsp_rdat <= res_data;
      end
   end

   always_ff @(posedge nice_clk) begin
      if (rst) begin
         rsp_err <= 1'b0;
      end else if (!hold) begin
         rsp_err <= err_sticky;
      end
   end

   a_rsp_stable: assert property (@(posedge nice_clk) disable iff (rst)
      rsp_valid && !rsp_ready |=>
         rsp_valid && $stable(rsp_rdat) && $stable(rsp_err));

endmodule

`default_nettype wire

// ==== hw/nice_core.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "nice_cfg.svh"

module nice_core (
   input  logic               nice_clk,
   input  logic               rst,
   output logic               nice_active,
   output logic               nice_mem_holdup,
   input  logic               req_valid,
   output logic               req_ready,
   input  nice_pkg::word_t    req_inst,
   input  nice_pkg::word_t    req_rs1,
   input  nice_pkg::word_t    req_rs2,
   output logic               rsp_valid,
   input  logic               rsp_ready,
   output nice_pkg::word_t    rsp_rdat,
   output logic               rsp_err,
   output logic               icb_cmd_valid,
   input  logic               icb_cmd_ready,
   output nice_pkg::addr_t    icb_cmd_addr,
   output logic               icb_cmd_read,
   output nice_pkg::word_t    icb_cmd_wdata,
   output logic [1:0]         icb_cmd_size,
   input  logic               icb_rsp_valid,
   output logic               icb_rsp_ready,
   input  nice_pkg::word_t    icb_rsp_rdata,
   input  logic               icb_rsp_err
);
   import nice_pkg::*;

   nice_op_e    dec_op;
   nice_op_e    op_r;
   nice_op_e    op_cur;
   nice_state_e state;
   pic_idx_t    idx_r;
   pic_idx_t    rd_idx;
   word_t       act_data;
   word_t       last_data;
   logic        req_hsk;
   logic        burst_start;
   logic        load_done;
   logic        err_sticky;
   logic        wr_en;

   ////////////////////
   // request capture
   ////////////////////

   // rs2 has no use in jlsd or jact
   assign req_hsk = req_valid & req_ready;

   always_ff @(posedge nice_clk) begin
      if (rst) begin
         op_r <= op_illegal;
      end else if (req_hsk) begin
         op_r <= dec_op;
      end
   end

   always_ff @(posedge nice_clk) begin
      if (req_hsk) begin
         idx_r <= req_rs1[`NICE_PIC_IDX_W-1:0];
      end
   end

   // idle works on the live request, later on the captured one
   assign op_cur = (state == st_idle) ? dec_op : op_r;
   assign rd_idx = (state == st_idle) ? req_rs1[`NICE_PIC_IDX_W-1:0] : idx_r;

   // every response in a burst goes to the buffer
   assign wr_en = (state == st_load) & icb_rsp_valid & icb_rsp_ready;

   ////////////////////
   // fixed icb fields
   ////////////////////

   // read only, whole words
   assign icb_cmd_read  = 1'b1;
   assign icb_cmd_wdata = '0;
   assign icb_cmd_size  = `NICE_CMD_SIZE_WORD;
   assign icb_rsp_ready = 1'b1;

   nice_decode u_decode (
      .req_inst  (req_inst),
      .req_valid (req_valid),
      .op        (dec_op)
   );

   nice_seq u_seq (
      .nice_clk        (nice_clk),
      .rst             (rst),
      .req_valid       (req_valid),
      .op              (op_cur),
      .icb_cmd_ready   (icb_cmd_ready),
      .icb_rsp_valid   (icb_rsp_valid),
      .icb_rsp_err     (icb_rsp_err),
      .rsp_ready       (rsp_ready),
      .req_ready       (req_ready),
      .state           (state),
      .burst_start     (burst_start),
      .load_done       (load_done),
      .err_sticky      (err_sticky),
      .nice_active     (nice_active),
      .nice_mem_holdup (nice_mem_holdup)
   );

   nice_lsu u_lsu (
      .nice_clk      (nice_clk),
      .rst           (rst),
      .burst_start   (burst_start),
      .req_rs1       (addr_t'(req_rs1)),
      .icb_cmd_ready (icb_cmd_ready),
      .icb_cmd_valid (icb_cmd_valid),
      .icb_cmd_addr  (icb_cmd_addr)
   );

   nice_picbuf u_picbuf (
      .nice_clk    (nice_clk),
      .rst         (rst),
      .burst_start (burst_start),
      .wr_en       (wr_en),
      .wr_data     (icb_rsp_rdata),
      .rd_idx      (rd_idx),
      .act_data    (act_data),
      .last_data   (last_data)
   );

   nice_rsp u_rsp (
      .nice_clk   (nice_clk),
      .rst        (rst),
      .state      (state),
      .op         (op_cur),
      .act_data   (act_data),
      .last_data  (last_data),
      .err_sticky (err_sticky),
      .rsp_ready  (rsp_ready),
      .rsp_valid  (rsp_valid),
      .rsp_rdat   (rsp_rdat),
      .rsp_err    (rsp_err)
   );

   // jlsd answers with the word of the final memory response
   a_load_result: assert property (@(posedge nice_clk) disable iff (rst)
      load_done |=> rsp_valid && (rsp_rdat == $past(icb_rsp_rdata)));

endmodule

`default_nettype wire

// ==== tb/tb_nice_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "nice_cfg.svh"

module tb_nice_mem (
   input  logic            nice_clk,
   input  logic            rst,
   input  nice_pkg::addr_t exp_base,
   input  logic            clr,
   input  logic            icb_cmd_valid,
   input  nice_pkg::addr_t icb_cmd_addr,
   input  logic            icb_cmd_read,
   output logic            icb_cmd_ready,
   output logic            icb_rsp_valid,
   output nice_pkg::word_t icb_rsp_rdata,
   output logic            icb_rsp_err,
   output int              cmd_count,
   output logic            burst_err,
   output int              fail_count
);
   import nice_pkg::*;

   // 4 KiB window, upper address bits alias
   localparam int MEM_WORDS = 1024;

   word_t mem_words [MEM_WORDS];

   // pending responses, oldest first
   word_t q_data [$];
   logic  q_err [$];
   int    q_due [$];
   int    cycle;
   addr_t exp_addr;

   function automatic logic [9:0] word_index(input addr_t addr);
      return addr[11:2];
   endfunction

   initial begin
      icb_cmd_ready = 1'b0;
      icb_rsp_valid = 1'b0;
      icb_rsp_rdata = '0;
      icb_rsp_err   = 1'b0;
      cmd_count     = 0;
      burst_err     = 1'b0;
      fail_count    = 0;
      cycle         = 0;
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem_words[10'(i)] = $urandom;
      end
      forever begin
         @(posedge nice_clk);
         #1;
         cycle++;
         // ready drops about three cycles in ten
         icb_cmd_ready = (!rst) && ($urandom_range(9) < 32'd7);

         ////////////////////
         // response side
         ////////////////////

         // one response per cycle, in command order
         if (q_due.size() > 0 && q_due[0] <= cycle) begin
            icb_rsp_valid = 1'b1;
            icb_rsp_rdata = q_data.pop_front();
            icb_rsp_err   = q_err.pop_front();
            void'(q_due.pop_front());
            if (icb_rsp_err) begin
               burst_err = 1'b1;
            end
         end else begin
            icb_rsp_valid = 1'b0;
            icb_rsp_rdata = '0;
            icb_rsp_err   = 1'b0;
         end

         ////////////////////
         // command side
         ////////////////////

         @(negedge nice_clk);
         if (clr) begin
            cmd_count = 0;
            burst_err = 1'b0;
         end
         if (!rst && icb_cmd_valid && icb_cmd_ready) begin
            exp_addr = exp_base + addr_t'(cmd_count * `NICE_WORD_BYTES);
            if (cmd_count >= `NICE_PIC_WORDS) begin
               fail_count++;
               $display("error at %0t ns: extra memory command at %h", $time, icb_cmd_addr);
            end else if (icb_cmd_addr !== exp_addr) begin
               fail_count++;
               $display("error at %0t ns: command %0d address %h, expected %h",
                        $time, cmd_count, icb_cmd_addr, exp_addr);
            end
            if (icb_cmd_read !== 1'b1) begin
               fail_count++;
               $display("error at %0t ns: memory command is not a read", $time);
            end
            // about one response in twenty fails
            q_data.push_back(mem_words[word_index(icb_cmd_addr)]);
            q_err.push_back($urandom_range(19) == 0);
            q_due.push_back(cycle + 1 + int'($urandom_range(3)));
            cmd_count++;
         end
      end
   end

endmodule

`default_nettype wire

// ==== tb/tb_nice_core.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "nice_cfg.svh"

module tb_nice_core;
   import nice_pkg::*;

   localparam int CLK_PERIOD    = 4;
   localparam int N_LOAD        = 6;
   localparam int N_ERR_MAX     = 40;
   localparam int N_ACT         = 20;
   localparam int N_ILLEGAL     = 12;
   localparam int N_BACKPRESS   = 30;
   localparam int N_INSTR       = N_LOAD + N_ERR_MAX + N_ACT + N_ILLEGAL + N_BACKPRESS;
   // budget per issued instruction
   localparam int CYC_PER_INSTR = 200;

   logic       nice_clk;
   logic       rst;
   logic       nice_active;
   logic       nice_mem_holdup;
   logic       req_valid;
   logic       req_ready;
   word_t      req_inst;
   word_t      req_rs1;
   word_t      req_rs2;
   logic       rsp_valid;
   logic       rsp_ready;
   word_t      rsp_rdat;
   logic       rsp_err;
   logic       icb_cmd_valid;
   logic       icb_cmd_ready;
   addr_t      icb_cmd_addr;
   logic       icb_cmd_read;
   word_t      icb_cmd_wdata;
   logic [1:0] icb_cmd_size;
   logic       icb_rsp_valid;
   logic       icb_rsp_ready;
   word_t      icb_rsp_rdata;
   logic       icb_rsp_err;

   // memory model control and status
   addr_t      mem_base;
   logic       mem_clr;
   int         mem_cmd_count;
   logic       mem_burst_err;
   int         mem_fail_count;

   // mirror of the picture buffer
   word_t      model_buf [`NICE_PIC_WORDS];
   logic       bp_on;
   int         checks;
   int         errors;
   int         tests;
   int         test_err0;
   int         test_chk0;
   string      test_name;

   nice_core UUT (
      .nice_clk        (nice_clk),
      .rst             (rst),
      .nice_active     (nice_active),
      .nice_mem_holdup (nice_mem_holdup),
      .req_valid       (req_valid),
      .req_ready       (req_ready),
      .req_inst        (req_inst),
      .req_rs1         (req_rs1),
      .req_rs2         (req_rs2),
      .rsp_valid       (rsp_valid),
      .rsp_ready       (rsp_ready),
      .rsp_rdat        (rsp_rdat),
      .rsp_err         (rsp_err),
      .icb_cmd_valid   (icb_cmd_valid),
      .icb_cmd_ready   (icb_cmd_ready),
      .icb_cmd_addr    (icb_cmd_addr),
      .icb_cmd_read    (icb_cmd_read),
      .icb_cmd_wdata   (icb_cmd_wdata),
      .icb_cmd_size    (icb_cmd_size),
      .icb_rsp_valid   (icb_rsp_valid),
      .icb_rsp_ready   (icb_rsp_ready),
      .icb_rsp_rdata   (icb_rsp_rdata),
      .icb_rsp_err     (icb_rsp_err)
   );

   tb_nice_mem MEM (
      .nice_clk      (nice_clk),
      .rst           (rst),
      .exp_base      (mem_base),
      .clr           (mem_clr),
      .icb_cmd_valid (icb_cmd_valid),
      .icb_cmd_addr  (icb_cmd_addr),
      .icb_cmd_read  (icb_cmd_read),
      .icb_cmd_ready (icb_cmd_ready),
      .icb_rsp_valid (icb_rsp_valid),
      .icb_rsp_rdata (icb_rsp_rdata),
      .icb_rsp_err   (icb_rsp_err),
      .cmd_count     (mem_cmd_count),
      .burst_err     (mem_burst_err),
      .fail_count    (mem_fail_count)
   );

   initial begin
      nice_clk = 1'b0;
      forever #(CLK_PERIOD / 2) nice_clk = ~nice_clk;
   end

   // watchdog
   initial begin
      #(CLK_PERIOD * CYC_PER_INSTR * (N_INSTR + 1));
      $display("timeout: the run did not finish within %0d cycles",
               CYC_PER_INSTR * (N_INSTR + 1));
      $display("Result: FAILED");
      $finish;
   end

   ////////////////////
   // helpers
   ////////////////////

   function automatic int fail_total();
      return errors + mem_fail_count;
   endfunction

   task automatic log_error(input string msg);
      errors++;
      $display("error at %0t ns: %s", $time, msg);
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_err0 = fail_total();
      test_chk0 = checks;
   endtask

   task automatic end_test();
      tests++;
      $display("test %-12s done: %0d checks, %0d errors",
               test_name, checks - test_chk0, fail_total() - test_err0);
   endtask

   // status outputs and the fixed icb fields
   task automatic check_side_outputs(input logic exp_active, input logic exp_holdup);
      checks += 3;
      if (nice_active !== exp_active) begin
         log_error($sformatf("nice_active %b, expected %b", nice_active, exp_active));
      end
      if (nice_mem_holdup !== exp_holdup) begin
         log_error($sformatf("nice_mem_holdup %b, expected %b",
                             nice_mem_holdup, exp_holdup));
      end
      // read only, size code 2 is a word, responses always taken
      if (icb_cmd_wdata !== '0 || icb_cmd_size !== 2'b10 || icb_rsp_ready !== 1'b1) begin
         log_error($sformatf("icb wdata %h size %b rsp_ready %b, expected 0, 10, 1",
                             icb_cmd_wdata, icb_cmd_size, icb_rsp_ready));
      end
   endtask

   // rd, rs1 and rs2 fields are free
   function automatic word_t make_rtype(input logic [6:0] f7, input logic [2:0] f3);
      return {f7, 5'($urandom), 5'($urandom), f3, 5'($urandom), `NICE_OPC_CUSTOM3};
   endfunction

   function automatic logic is_known(input word_t inst);
      logic custom3;
      custom3 = (inst[6:0] == `NICE_OPC_CUSTOM3);
      return custom3 &&
             ((inst[14:12] == `NICE_F3_JLSD && inst[31:25] == `NICE_F7_JLSD) ||
              (inst[14:12] == `NICE_F3_JACT && inst[31:25] == `NICE_F7_JACT));
   endfunction

   function automatic word_t rand_illegal();
      word_t inst;
      inst = $urandom;
      // half keep custom3, only the function codes are wrong
      if ($urandom_range(1) == 1) begin
         inst[6:0] = `NICE_OPC_CUSTOM3;
      end
      while (is_known(inst)) begin
         inst[31:25] = 7'($urandom);
      end
      return inst;
   endfunction

   // negative words give zero
   function automatic word_t activate(input word_t w);
      return ($signed(w) < 0) ? '0 : w;
   endfunction

   function automatic logic [9:0] mem_index(input addr_t addr);
      return addr[11:2];
   endfunction

   ////////////////////
   // one instruction
   ////////////////////

   // lat counts idle cycles between request and first rsp_valid
   task automatic issue(input word_t inst, input word_t rs1,
                        output word_t rdat, output logic err, output int lat);
      word_t seen_rdat;
      logic  seen_err;
      logic  seen;
      logic  done;
      logic  is_load;
      lat       = 0;
      seen      = 1'b0;
      done      = 1'b0;
      seen_rdat = '0;
      seen_err  = 1'b0;
      is_load   = (inst[6:0] == `NICE_OPC_CUSTOM3) && (inst[14:12] == `NICE_F3_JLSD) &&
                  (inst[31:25] == `NICE_F7_JLSD);
      req_valid = 1'b1;
      req_inst  = inst;
      req_rs1   = rs1;
      req_rs2   = $urandom;
      @(negedge nice_clk);
      while (!req_ready) begin
         @(posedge nice_clk);
         #1;
         @(negedge nice_clk);
      end
      // still idle, the request alone makes the core active
      check_side_outputs(1'b1, 1'b0);
      @(posedge nice_clk);
      #1;
      req_valid = 1'b0;
      req_inst  = '0;
      req_rs1   = '0;
      // response, ready random under back-pressure
      while (!done) begin
         rsp_ready = bp_on ? ($urandom_range(2) != 0) : 1'b1;
         @(negedge nice_clk);
         // holdup only while a burst still waits for memory
         check_side_outputs(1'b1, is_load && !rsp_valid);
         if (rsp_valid) begin
            if (seen && (rsp_rdat !== seen_rdat || rsp_err !== seen_err)) begin
               log_error("response changed before its handshake");
            end
            seen      = 1'b1;
            seen_rdat = rsp_rdat;
            seen_err  = rsp_err;
            done      = rsp_ready;
         end else begin
            if (seen) begin
               log_error("response dropped before its handshake");
            end
            lat++;
         end
         @(posedge nice_clk);
         #1;
      end
      rsp_ready = 1'b0;
      rdat      = seen_rdat;
      err       = seen_err;
      // a second response here would be a duplicate
      @(negedge nice_clk);
      checks++;
      if (rsp_valid) begin
         log_error("response repeated after its handshake");
      end
      check_side_outputs(1'b0, 1'b0);
      @(posedge nice_clk);
      #1;
   endtask

   task automatic run_load(input word_t base, output logic had_err);
      word_t rdat;
      logic  err;
      int    lat;
      mem_base = base;
      mem_clr  = 1'b1;
      @(negedge nice_clk);
      @(posedge nice_clk);
      #1;
      mem_clr = 1'b0;
      issue(make_rtype(`NICE_F7_JLSD, `NICE_F3_JLSD), base, rdat, err, lat);
      for (int i = 0; i < `NICE_PIC_WORDS; i++) begin
         model_buf[pic_idx_t'(i)] =
            MEM.mem_words[mem_index(base + addr_t'(i * `NICE_WORD_BYTES))];
      end
      checks += 3;
      if (mem_cmd_count != `NICE_PIC_WORDS) begin
         log_error($sformatf("burst had %0d commands, expected %0d",
                             mem_cmd_count, `NICE_PIC_WORDS));
      end
      if (rdat !== model_buf[`NICE_PIC_WORDS-1]) begin
         log_error($sformatf("jlsd data %h, expected %h", rdat,
                             model_buf[`NICE_PIC_WORDS-1]));
      end
      if (err !== mem_burst_err) begin
         log_error($sformatf("jlsd rsp_err %b, expected %b", err, mem_burst_err));
      end
      had_err = mem_burst_err;
   endtask

   task automatic run_act(input word_t rs1);
      word_t rdat;
      word_t exp;
      logic  err;
      int    lat;
      issue(make_rtype(`NICE_F7_JACT, `NICE_F3_JACT), rs1, rdat, err, lat);
      exp = activate(model_buf[pic_idx_t'(rs1 % `NICE_PIC_WORDS)]);
      checks += 3;
      if (rdat !== exp) begin
         log_error($sformatf("jact rs1 %h data %h, expected %h", rs1, rdat, exp));
      end
      if (err !== 1'b0) begin
         log_error("jact answered with rsp_err high");
      end
      if (lat != 0) begin
         log_error($sformatf("jact response %0d cycles late", lat));
      end
   endtask

   task automatic run_illegal(input word_t inst);
      word_t rdat;
      logic  err;
      int    lat;
      issue(inst, $urandom, rdat, err, lat);
      checks += 3;
      if (rdat !== '0) begin
         log_error($sformatf("illegal %h data %h, expected zero", inst, rdat));
      end
      if (err !== 1'b1) begin
         log_error($sformatf("illegal %h answered with rsp_err low", inst));
      end
      if (lat != 0) begin
         log_error($sformatf("illegal response %0d cycles late", lat));
      end
   endtask

   ////////////////////
   // main sequence
   ////////////////////

   initial begin
      logic had_err;
      logic saw_clean;
      logic saw_err;
      int   n;
      void'($urandom(32'h25b9));
      rst       = 1'b1;
      req_valid = 1'b0;
      req_inst  = '0;
      req_rs1   = '0;
      req_rs2   = '0;
      rsp_ready = 1'b0;
      mem_base  = '0;
      mem_clr   = 1'b0;
      bp_on     = 1'b0;
      checks    = 0;
      errors    = 0;
      tests     = 0;
      repeat (4) @(posedge nice_clk);
      #1;
      rst = 1'b0;

      start_test("reset");
      @(negedge nice_clk);
      checks++;
      if (rsp_valid || icb_cmd_valid || nice_mem_holdup || req_ready) begin
         log_error("outputs not low after reset");
      end
      check_side_outputs(1'b0, 1'b0);
      @(posedge nice_clk);
      #1;
      end_test();

      // first loads also fill the buffer for jact
      start_test("load");
      for (int i = 0; i < N_LOAD; i++) begin
         run_load($urandom & 32'hffff_fffc, had_err);
      end
      end_test();

      // keep going until both outcomes were seen
      start_test("load_error");
      saw_clean = 1'b0;
      saw_err   = 1'b0;
      n         = 0;
      while (!(saw_clean && saw_err) && n < N_ERR_MAX) begin
         run_load($urandom & 32'hffff_fffc, had_err);
         if (had_err) begin
            saw_err = 1'b1;
         end else begin
            saw_clean = 1'b1;
         end
         n++;
      end
      checks++;
      if (!(saw_clean && saw_err)) begin
         log_error("bursts did not give both a clean and a failing result");
      end
      end_test();

      start_test("act");
      for (int i = 0; i < N_ACT; i++) begin
         run_act($urandom);
      end
      end_test();

      start_test("illegal");
      for (int i = 0; i < N_ILLEGAL; i++) begin
         run_illegal(rand_illegal());
      end
      end_test();

      // mixed traffic, rsp_ready toggles at random
      start_test("backpressure");
      bp_on = 1'b1;
      for (int i = 0; i < N_BACKPRESS; i++) begin
         case ($urandom_range(2))
            0: run_load($urandom & 32'hffff_fffc, had_err);
            1: run_act($urandom);
            default: run_illegal(rand_illegal());
         endcase
      end
      bp_on = 1'b0;
      end_test();

      $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, fail_total());
      if (fail_total() == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+include
hw/nice_pkg.sv
hw/nice_decode.sv
hw/nice_seq.sv
hw/nice_lsu.sv
hw/nice_picbuf.sv
hw/nice_rsp.sv
hw/nice_core.sv
tb/tb_nice_mem.sv
tb/tb_nice_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, from the project root.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f filelist.f \
   --top-module tb_nice_core -Mdir "$BUILD_DIR" -o sim_nice
if [ $? -ne 0 ]; then
   echo "compile failed"
   exit 1
fi

"./$BUILD_DIR/sim_nice" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
   exit 0
fi
exit 1
